/* rtl/fetch_pkg.sv */
////////////////////
// shared fetch types: parcel, parcel status,
// instruction word union, decode record, length rule
////////////////////

package fetch_pkg;

  // bus word holds two 16-bit parcels
  localparam int PARCELS_PER_WORD = 2;

  // one instruction parcel
  typedef logic [15:0] parcel_t;

  // status kept beside each parcel
  typedef struct packed {
    logic misaligned;
    logic error;
  } parcel_status_t;

  // bus word on the fetch side, parcel pair on the queue side
  typedef union packed {
    logic [31:0]                          word;
    parcel_t [PARCELS_PER_WORD-1:0]       parcels;
  } instr_word_u;

  // record handed to decode
  typedef struct packed {
    logic [31:0]    pc;
    instr_word_u    instr;
    logic           compressed;
    parcel_status_t status;
  } fetch_instr_t;

  ////////////////////
  // length decode
  ////////////////////

  // 32-bit instructions have both low bits set
  function automatic logic is_compressed(input parcel_t p);
    return p[1:0] != 2'b11;
  endfunction

endpackage

/* rtl/parcel_queue.sv */
////////////////////
// parcel queue: shift register of 16-bit parcels
// with per-parcel status and registered flags
////////////////////

`timescale 1ns/1ns

module parcel_queue import fetch_pkg::*; #(
  // depth in parcels, even and >= 4
  parameter int DEPTH = 8
)
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,

  // write side, one bus word per push
  input  instr_word_u                 parcel_i,
  input  logic [PARCELS_PER_WORD-1:0] parcel_valid_i,
  input  parcel_status_t              parcel_status_i,

  // read side, 0..2 parcels per cycle
  input  logic [1:0]                  parcel_rd_i,
  output instr_word_u                 parcel_q_o,
  output parcel_status_t              parcel_status_o,

  // occupancy flags
  output logic                        empty_o,
  output logic                        almost_empty_o,
  output logic                        full_o
);

  localparam int CNT_W = $clog2(DEPTH + 1);

  // parcel storage, entry 0 is the head
  parcel_t        [DEPTH-1:0]            parcel_sr;
  parcel_t        [DEPTH-1:0]            nxt_parcel_sr;
  parcel_status_t [DEPTH-1:0]            status_sr;
  parcel_status_t [DEPTH-1:0]            nxt_status_sr;

  // write parcels with leading invalid parcel removed
  parcel_t        [PARCELS_PER_WORD-1:0] wr_parcels;
  logic                                  wr_skip;
  logic           [1:0]                  push_cnt;

  logic           [CNT_W-1:0]            count_q;
  logic           [CNT_W-1:0]            nxt_count;

  ////////////////////
  // write alignment
  ////////////////////

  // upper-only push when fetch starts on the odd halfword
  assign wr_skip    = !parcel_valid_i[0] && parcel_valid_i[1];
  assign wr_parcels = wr_skip ? {parcel_t'(0), parcel_i.parcels[1]} : parcel_i.parcels;
  assign push_cnt   = 2'($countones(parcel_valid_i));

  assign nxt_count  = count_q + CNT_W'(push_cnt) - CNT_W'(parcel_rd_i);

  // write behind the last stored parcel, then shift out the pulled ones
  always_comb
  begin
    nxt_parcel_sr = parcel_sr;
    nxt_status_sr = status_sr;

    for (int n = 0; n < PARCELS_PER_WORD; n++)
    begin
      if (n < int'(push_cnt) && (int'(count_q) + n) < DEPTH)
      begin
        nxt_parcel_sr[int'(count_q) + n] = wr_parcels[n];
        // instruction boundaries unknown here, so each parcel gets the status
        nxt_status_sr[int'(count_q) + n] = parcel_status_i;
      end
    end

    nxt_parcel_sr = nxt_parcel_sr >> (parcel_rd_i * $bits(parcel_t));
    nxt_status_sr = nxt_status_sr >> (parcel_rd_i * $bits(parcel_status_t));
  end

  // data only, validity lives in count_q
  always_ff @(posedge clk_i)
  begin
    parcel_sr <= nxt_parcel_sr;
    status_sr <= nxt_status_sr;
  end

  ////////////////////
  // occupancy
  ////////////////////

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      count_q        <= '0;
      empty_o        <= 1'b1;
      almost_empty_o <= 1'b1;
      full_o         <= 1'b0;
    end
    else if (flush_i)
    begin
      count_q        <= '0;
      empty_o        <= 1'b1;
      almost_empty_o <= 1'b1;
      full_o         <= 1'b0;
    end
    else
    begin
      count_q        <= nxt_count;
      empty_o        <= nxt_count == '0;
      almost_empty_o <= nxt_count < CNT_W'(2);
      // full once a whole word no longer fits
      full_o         <= nxt_count > CNT_W'(DEPTH - 2);
    end
  end

  // head pair and status of the first parcel
  assign parcel_q_o.parcels = parcel_sr[PARCELS_PER_WORD-1:0];
  assign parcel_status_o    = status_sr[0];

  ////////////////////
  // checks
  ////////////////////

  // stored plus pushed never exceeds the depth
  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !flush_i |-> (int'(count_q) + int'(push_cnt)) <= DEPTH);

  // aligner never takes more than is stored
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    int'(parcel_rd_i) <= int'(count_q));

  // fetcher only starts with room for a whole word
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    full_o |-> parcel_valid_i == '0);

endmodule

/* rtl/wb_fetcher.sv */
////////////////////
// wishbone classic read master, walks the fetch pc
////////////////////

`timescale 1ns/1ns

module wb_fetcher import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        redirect_i,
  input  logic [31:0]                 redirect_pc_i,
  input  logic                        queue_full_i,

  // wishbone master
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  output logic [31:0]                 wb_adr_o,
  input  logic [31:0]                 wb_dat_i,
  input  logic                        wb_ack_i,
  input  logic                        wb_err_i,

  // queue push, valid only in the terminating cycle
  output instr_word_u                 push_word_o,
  output logic [PARCELS_PER_WORD-1:0] push_valid_o,
  output parcel_status_t              push_status_o
);

  // drop = finish a cycle whose data is stale after redirect
  typedef enum logic [1:0] {ST_IDLE, ST_BUS, ST_DROP} state_e;

  state_e      state_q;
  state_e      state_d;
  logic [31:0] pc_q;
  logic [31:0] pc_d;
  logic [31:0] adr_q;
  logic        bus_done;

  assign bus_done = wb_ack_i | wb_err_i;

  always_comb
  begin
    state_d = state_q;
    pc_d    = pc_q;
    case (state_q)
      ST_IDLE:
        if (redirect_i)
          pc_d = redirect_pc_i;
        else if (!queue_full_i)
          state_d = ST_BUS;
      ST_BUS:
        if (redirect_i)
        begin
          pc_d    = redirect_pc_i;
          state_d = bus_done ? ST_IDLE : ST_DROP;
        end
        else if (bus_done)
        begin
          // on to the next word boundary
          pc_d    = {pc_q[31:2] + 30'd1, 2'b00};
          state_d = ST_IDLE;
        end
      ST_DROP:
      begin
        if (redirect_i)
          pc_d = redirect_pc_i;
        if (bus_done)
          state_d = ST_IDLE;
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ST_IDLE;
      pc_q    <= RESET_PC;
    end
    else
    begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

  // address frozen for the whole cycle, pc may move during drop
  always_ff @(posedge clk_i)
  begin
    if (state_q == ST_IDLE)
      adr_q <= {pc_q[31:2], 2'b00};
  end

  assign wb_cyc_o = state_q != ST_IDLE;
  assign wb_stb_o = state_q != ST_IDLE;
  assign wb_we_o  = 1'b0;
  assign wb_adr_o = adr_q;

  // odd halfword start keeps only the upper parcel
  assign push_word_o.word       = wb_dat_i;
  assign push_valid_o           = (state_q == ST_BUS && bus_done && !redirect_i) ?
                                  (pc_q[1] ? 2'b10 : 2'b11) : 2'b00;
  assign push_status_o.misaligned = pc_q[0];
  assign push_status_o.error      = wb_err_i;

  ////////////////////
  // bus protocol checks
  ////////////////////

  // request held with the same address until ack or err
  a_adr_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    wb_stb_o && !bus_done |=> wb_stb_o && $stable(wb_adr_o));

endmodule

/* rtl/instr_aligner.sv */
////////////////////
// instruction aligner: parcels from queue head to decode
////////////////////

`timescale 1ns/1ns

module instr_aligner import fetch_pkg::*; #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
  input  logic           clk_i,
  input  logic           rst_ni,
  input  logic           redirect_i,
  input  logic [31:0]    redirect_pc_i,

  // queue head
  input  instr_word_u    head_i,
  input  parcel_status_t head_status_i,
  input  logic           empty_i,
  input  logic           almost_empty_i,
  output logic [1:0]     pull_cnt_o,

  // decode handshake
  output fetch_instr_t   instr_o,
  output logic           instr_valid_o,
  input  logic           instr_ready_i
);

  logic [31:0] pc_q;
  logic        compressed;
  logic        transfer;

  // length from the low bits of the head parcel
  assign compressed = is_compressed(head_i.parcels[0]);

  // full instruction present, or a fault that must reach decode now
  // stale head is hidden while a redirect flushes the queue
  assign instr_valid_o = !redirect_i && !empty_i &&
                         (compressed || !almost_empty_i || head_status_i.error);

  assign transfer = instr_valid_o && instr_ready_i;

  // faulting 32-bit instruction may only have one parcel stored
  assign pull_cnt_o = !transfer                     ? 2'd0 :
                      (compressed || almost_empty_i) ? 2'd1 : 2'd2;

  // pc tracks the consumed parcels
  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
      pc_q <= RESET_PC;
    else if (redirect_i)
      pc_q <= redirect_pc_i;
    else if (transfer)
      pc_q <= pc_q + {29'd0, pull_cnt_o, 1'b0};
  end

  assign instr_o.pc         = pc_q;
  // 16-bit instruction zero extended
  assign instr_o.instr.word = compressed ? {16'h0000, head_i.parcels[0]} : head_i.word;
  assign instr_o.compressed = compressed;
  assign instr_o.status     = head_status_i;

  ////////////////////
  // handshake checks
  ////////////////////

  // offered instruction waits for decode unless fetch is redirected
  a_hold_stalled : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_o && !instr_ready_i |=>
      redirect_i || (instr_valid_o && $stable(instr_o.pc)));

endmodule

/* rtl/fetch_top.sv */
////////////////////
// fetch front end: fetcher, parcel queue, aligner
////////////////////

`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; #(
  parameter int          DEPTH    = 8,
  parameter logic [31:0] RESET_PC = 32'h0000_0000
)
(
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         redirect_i,
  input  logic [31:0]  redirect_pc_i,

  // wishbone master
  output logic         wb_cyc_o,
  output logic         wb_stb_o,
  output logic         wb_we_o,
  output logic [31:0]  wb_adr_o,
  input  logic [31:0]  wb_dat_i,
  input  logic         wb_ack_i,
  input  logic         wb_err_i,

  // to decode
  output fetch_instr_t instr_o,
  output logic         instr_valid_o,
  input  logic         instr_ready_i
);

  // fetcher to queue
  instr_word_u                 push_word;
  logic [PARCELS_PER_WORD-1:0] push_valid;
  parcel_status_t              push_status;
  logic                        queue_full;

  // queue to aligner
  instr_word_u                 head;
  parcel_status_t              head_status;
  logic                        queue_empty;
  logic                        queue_almost_empty;
  logic [1:0]                  pull_cnt;

  wb_fetcher #(
    .RESET_PC (RESET_PC)
  ) u_fetcher (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .queue_full_i  (queue_full),
    .wb_cyc_o      (wb_cyc_o),
    .wb_stb_o      (wb_stb_o),
    .wb_we_o       (wb_we_o),
    .wb_adr_o      (wb_adr_o),
    .wb_dat_i      (wb_dat_i),
    .wb_ack_i      (wb_ack_i),
    .wb_err_i      (wb_err_i),
    .push_word_o   (push_word),
    .push_valid_o  (push_valid),
    .push_status_o (push_status)
  );

  // redirect empties the queue
  parcel_queue #(
    .DEPTH (DEPTH)
  ) u_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (redirect_i),
    .parcel_i        (push_word),
    .parcel_valid_i  (push_valid),
    .parcel_status_i (push_status),
    .parcel_rd_i     (pull_cnt),
    .parcel_q_o      (head),
    .parcel_status_o (head_status),
    .empty_o         (queue_empty),
    .almost_empty_o  (queue_almost_empty),
    .full_o          (queue_full)
  );

  instr_aligner #(
    .RESET_PC (RESET_PC)
  ) u_aligner (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .redirect_i     (redirect_i),
    .redirect_pc_i  (redirect_pc_i),
    .head_i         (head),
    .head_status_i  (head_status),
    .empty_i        (queue_empty),
    .almost_empty_i (queue_almost_empty),
    .pull_cnt_o     (pull_cnt),
    .instr_o        (instr_o),
    .instr_valid_o  (instr_valid_o),
    .instr_ready_i  (instr_ready_i)
  );

endmodule

/* tb/wb_rom_model.sv */
////////////////////
// wishbone classic rom slave, hashed content,
// random wait states and one err address
////////////////////

`timescale 1ns/1ns

module wb_rom_model #(
  parameter logic [31:0] SEED     = 32'd24,
  parameter logic [31:0] ERR_ADDR = 32'h0000_0400
)
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic [31:0] wb_adr_i,
  output logic [31:0] wb_dat_o,
  output logic        wb_ack_o,
  output logic        wb_err_o
);

  logic [31:0] rng_q;
  logic [1:0]  wait_q;
  logic        busy_q;
  logic        req;

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // hash of the word address, length bits forced per halfword
  function automatic logic [31:0] word_at(input logic [31:0] addr);
    logic [31:0] h;
    logic [31:0] k;
    h = lcg_next({addr[31:2], 2'b00} ^ SEED);
    k = lcg_next(h);
    h[1:0]   = k[28] ? 2'b11 : {1'b0, k[27]};
    h[17:16] = k[30] ? 2'b11 : {1'b0, k[29]};
    return h;
  endfunction

  // open request, not answered yet
  assign req = wb_cyc_i && wb_stb_i && !wb_ack_o && !wb_err_o;

  always_ff @(posedge clk_i, negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      rng_q    <= SEED;
      wait_q   <= 2'd0;
      busy_q   <= 1'b0;
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      wb_dat_o <= '0;
    end
    else
    begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
      if (req && !busy_q && rng_q[31:30] != 2'd0)
      begin
        // first request cycle draws 1..3 wait states
        busy_q <= 1'b1;
        wait_q <= rng_q[31:30] - 2'd1;
        rng_q  <= lcg_next(rng_q);
      end
      else if (req && busy_q && wait_q != 2'd0)
        wait_q <= wait_q - 2'd1;
      else if (req)
      begin
        // data goes out with err too
        busy_q   <= 1'b0;
        wb_ack_o <= wb_adr_i[31:2] != ERR_ADDR[31:2];
        wb_err_o <= wb_adr_i[31:2] == ERR_ADDR[31:2];
        wb_dat_o <= word_at(wb_adr_i);
        if (!busy_q)
          rng_q <= lcg_next(rng_q);
      end
    end
  end

endmodule

/* tb/fetch_tb.sv */
////////////////////
// fetch front end testbench: directed tests,
// reference model, watchdog, result line
////////////////////

`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

  localparam int          DEPTH       = 8;
  localparam logic [31:0] RESET_PC    = 32'h0000_0000;
  localparam logic [31:0] ROM_SEED    = 32'd24;
  localparam logic [31:0] ERR_ADDR    = 32'h0000_0400;
  // instructions over all tests, sets the watchdog
  localparam int          TOTAL_INSTR = 40 + 60 + 2 * 20 + 24 + 1 + 8;

  logic         clk;
  logic         rst_n;
  logic         redirect;
  logic [31:0]  redirect_pc;
  logic         instr_ready;
  logic         instr_valid;
  fetch_instr_t instr;

  logic         wb_cyc;
  logic         wb_stb;
  logic         wb_we;
  logic [31:0]  wb_adr;
  logic [31:0]  wb_dat;
  logic         wb_ack;
  logic         wb_err;

  int           n_errors;
  int           n_checks;
  logic [31:0]  rng_state;
  logic         error_seen;

  fetch_top #(
    .DEPTH    (DEPTH),
    .RESET_PC (RESET_PC)
  ) DUT (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .wb_cyc_o      (wb_cyc),
    .wb_stb_o      (wb_stb),
    .wb_we_o       (wb_we),
    .wb_adr_o      (wb_adr),
    .wb_dat_i      (wb_dat),
    .wb_ack_i      (wb_ack),
    .wb_err_i      (wb_err),
    .instr_o       (instr),
    .instr_valid_o (instr_valid),
    .instr_ready_i (instr_ready)
  );

  wb_rom_model #(
    .SEED     (ROM_SEED),
    .ERR_ADDR (ERR_ADDR)
  ) u_rom (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_adr_i (wb_adr),
    .wb_dat_o (wb_dat),
    .wb_ack_o (wb_ack),
    .wb_err_o (wb_err)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = lcg_next(rng_state);
    return rng_state;
  endfunction

  // same hash and length forcing as the rom
  function automatic logic [31:0] rom_word(input logic [31:0] addr);
    logic [31:0] h;
    logic [31:0] k;
    h = lcg_next({addr[31:2], 2'b00} ^ ROM_SEED);
    k = lcg_next(h);
    h[1:0]   = k[28] ? 2'b11 : {1'b0, k[27]};
    h[17:16] = k[30] ? 2'b11 : {1'b0, k[29]};
    return h;
  endfunction

  function automatic logic [15:0] parcel_at(input logic [31:0] pc);
    logic [31:0] w;
    w = rom_word(pc);
    return pc[1] ? w[31:16] : w[15:0];
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    n_errors++;
    $display("** Error at %0t ns: %s got %h expected %h", $time, what, got, exp);
  endtask

  task automatic report_failure(input string msg);
    n_errors++;
    $display("failure at %0t ns: %s", $time, msg);
  endtask

  ////////////////////
  // stimulus helpers
  ////////////////////

  // one cycle pulse from the current edge
  task automatic apply_redirect(input logic [31:0] pc);
    redirect    <= 1'b1;
    redirect_pc <= pc;
    @(posedge clk);
    redirect    <= 1'b0;
  endtask

  task automatic wait_transfer(output fetch_instr_t got);
    @(posedge clk);
    while (!(instr_valid && instr_ready))
      @(posedge clk);
    got = instr;
  endtask

  // compare count transfers against the model, optional random stalls
  // stops early at the first instruction inside the err word
  task automatic run_stream(input logic [31:0] start_pc, input int count, input logic stall);
    logic [31:0] exp_pc;
    logic [31:0] exp_word;
    logic [31:0] held_pc;
    logic [31:0] rnd;
    logic [15:0] p0;
    logic        exp_c;
    logic        exp_err;
    logic        was_stalled;
    int          got;
    int          run_len;
    exp_pc      = start_pc;
    held_pc     = '0;
    was_stalled = 1'b0;
    got         = 0;
    run_len     = 0;
    while (got < count)
    begin
      @(posedge clk);
      // offer must survive a stall unchanged
      if (was_stalled && !instr_valid)
        report_failure("instr_valid_o dropped while instr_ready_i was low");
      if (was_stalled && instr_valid && instr.pc != held_pc)
        report_mismatch("pc under stall", instr.pc, held_pc);
      // fetch is read only
      if (wb_we)
        report_mismatch("wb_we_o", 32'(wb_we), 32'd0);
      if (wb_stb && !wb_cyc)
        report_failure("wb_stb_o high without wb_cyc_o");
      if (instr_valid && instr_ready)
      begin
        p0       = parcel_at(exp_pc);
        exp_c    = p0[1:0] != 2'b11;
        exp_word = exp_c ? {16'h0000, p0} : {parcel_at(exp_pc + 32'd2), p0};
        exp_err  = exp_pc[31:2] == ERR_ADDR[31:2];
        n_checks++;
        if (instr.pc != exp_pc)
          report_mismatch("pc", instr.pc, exp_pc);
        if (exp_err)
        begin
          if (!instr.status.error)
            report_mismatch("error bit", 32'(instr.status.error), 32'd1);
          else
            error_seen = 1'b1;
        end
        else
        begin
          if (instr.compressed != exp_c)
            report_mismatch("compressed flag", 32'(instr.compressed), 32'(exp_c));
          if (instr.instr.word != exp_word)
            report_mismatch("instruction", instr.instr.word, exp_word);
          if (instr.status != '0)
            report_mismatch("status", 32'(instr.status), 32'd0);
        end
        exp_pc = exp_pc + (exp_c ? 32'd2 : 32'd4);
        got    = exp_err ? count : got + 1;
      end
      was_stalled = instr_valid && !instr_ready;
      held_pc     = instr.pc;
      if (stall)
      begin
        if (run_len == 0)
        begin
          rnd         = next_rand();
          instr_ready <= rnd[31];
          run_len     = 1 + int'(rnd[27:24]);
        end
        run_len--;
      end
    end
    instr_ready <= 1'b1;
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic stream_after_reset();
    run_stream(RESET_PC, 40, 1'b0);
  endtask

  task automatic stalled_stream();
    apply_redirect(32'h0000_00c0);
    run_stream(32'h0000_00c0, 60, 1'b1);
  endtask

  task automatic redirect_restart();
    apply_redirect(32'h0000_00a2);
    run_stream(32'h0000_00a2, 20, 1'b0);
    // hit a pending bus cycle
    @(posedge clk);
    while (!(wb_cyc && !wb_ack && !wb_err))
      @(posedge clk);
    apply_redirect(32'h0000_01c6);
    run_stream(32'h0000_01c6, 20, 1'b0);
  endtask

  task automatic bus_error_fault();
    error_seen = 1'b0;
    apply_redirect(ERR_ADDR - 32'h10);
    run_stream(ERR_ADDR - 32'h10, 24, 1'b0);
    if (!error_seen)
      report_failure("no instruction with the error bit from the err address");
  endtask

  task automatic odd_pc_fault();
    fetch_instr_t got;
    apply_redirect(32'h0000_0155);
    wait_transfer(got);
    n_checks++;
    if (got.pc != 32'h0000_0155)
      report_mismatch("odd pc", got.pc, 32'h0000_0155);
    if (!got.status.misaligned)
      report_mismatch("misaligned bit", 32'(got.status.misaligned), 32'd1);
  endtask

  task automatic straddle_reassembly();
    logic [31:0] pc;
    logic [15:0] p;
    int          tries;
    // first 32-bit instruction on an upper halfword
    pc    = 32'h0000_0202;
    p     = parcel_at(pc);
    tries = 0;
    while (p[1:0] != 2'b11 && tries < 64)
    begin
      pc = pc + 32'd4;
      p  = parcel_at(pc);
      tries++;
    end
    if (p[1:0] != 2'b11)
      report_failure("ROM holds no 32-bit instruction across a word boundary");
    else
    begin
      apply_redirect(pc);
      run_stream(pc, 8, 1'b0);
    end
  endtask

  initial
  begin
    n_errors    = 0;
    n_checks    = 0;
    rng_state   = ROM_SEED;
    error_seen  = 1'b0;
    rst_n       <= 1'b0;
    redirect    <= 1'b0;
    redirect_pc <= '0;
    instr_ready <= 1'b1;
    repeat (16) @(posedge clk);
    if (wb_cyc || wb_stb || instr_valid)
      report_failure("bus request or instr_valid_o active during reset");
    rst_n <= 1'b1;

    stream_after_reset();
    stalled_stream();
    redirect_restart();
    bus_error_fault();
    odd_pc_fault();
    straddle_reassembly();

    $display("instructions checked: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

  // 40 cycles per instruction
  initial
  begin
    repeat (TOTAL_INSTR * 40) @(posedge clk);
    $display("watchdog expired after %0d cycles, tests did not complete", TOTAL_INSTR * 40);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

/* build.f */
rtl/fetch_pkg.sv
rtl/parcel_queue.sv
rtl/wb_fetcher.sv
rtl/instr_aligner.sv
rtl/fetch_top.sv
tb/wb_rom_model.sv
tb/fetch_tb.sv
